// File: design/rename_cfg_pkg.sv
/*
 * rename stage configuration
 * sizes shared by the free list, map table, rename queue and top
 */
package rename_cfg_pkg;

    localparam int ren_width  = 2;  // slots renamed per cycle
    localparam int log_regs   = 32; // architectural registers
    localparam int phys_regs  = 48; // physical register file size
    localparam int preg_bits  = 6;  // physical register number width
    localparam int lreg_bits  = 5;  // logical register number width
    localparam int rq_depth   = 4;  // rename queue entries
    localparam int snap_count = 4;  // branch snapshots held
    localparam int tag_bits   = 2;  // branch tag width

endpackage

// File: design/rename_types_pkg.sv
/*
 * rename stage bundles
 * decode input, commit return, redirect strobe and renamed output
 */
package rename_types_pkg;

    import rename_cfg_pkg::*;

    // one decoded instruction offered to rename
    typedef struct packed {
        logic                 valid;
        logic [15:0]          pc;        // stands in for the decode payload
        logic [lreg_bits-1:0] rd;
        logic [lreg_bits-1:0] rs1;
        logic [lreg_bits-1:0] rs2;
        logic                 is_branch;
        logic [tag_bits-1:0]  br_tag;    // snapshot slot for this branch
    } dec_slot_t;

    // commit return of a superseded mapping
    typedef struct packed {
        logic                 valid;
        logic [preg_bits-1:0] old_preg;
    } com_slot_t;

    // redirect strobe, restores the named snapshot
    typedef struct packed {
        logic                valid;
        logic [tag_bits-1:0] br_tag;
    } redir_t;

    // one renamed instruction as held in the rename queue
    typedef struct packed {
        logic                 valid;
        logic [15:0]          pc;
        logic [lreg_bits-1:0] rd;
        logic [preg_bits-1:0] prd;     // new mapping, 0 for x0
        logic [preg_bits-1:0] prs1;
        logic [preg_bits-1:0] prs2;
        logic [preg_bits-1:0] old_prd; // freed when this one commits
    } ren_slot_t;

endpackage

// File: design/free_list.sv
/*
 * physical register free list
 * bitmap of free registers, offers the lowest free ones each cycle,
 * keeps per-branch images that commit frees keep up to date
 */
`timescale 1ns/1ps

module free_list (
    input  logic                                                        clk,
    input  logic                                                        rst,
    output logic [rename_cfg_pkg::ren_width-1:0][rename_cfg_pkg::preg_bits-1:0] cand,
    output logic [rename_cfg_pkg::ren_width-1:0]                        cand_ok,
    input  logic [rename_cfg_pkg::ren_width-1:0]                        use_cand,
    input  logic [rename_cfg_pkg::ren_width-1:0]                        snap_en,
    input  logic [rename_cfg_pkg::ren_width-1:0][rename_cfg_pkg::tag_bits-1:0] snap_tag,
    input  rename_types_pkg::com_slot_t [rename_cfg_pkg::ren_width-1:0] com,
    input  rename_types_pkg::redir_t                                    redir
);
    import rename_cfg_pkg::*;

    logic [phys_regs-1:0]                  fl;       // 1 = free
    logic [snap_count-1:0][phys_regs-1:0]  snaps;    // images per branch tag
    logic [ren_width:0][phys_regs-1:0]     step;     // state after each slot
    logic [phys_regs-1:0]                  com_mask; // registers freed this cycle

    // lowest-first search, one candidate after another
    always_comb begin
        logic [phys_regs-1:0] avail;
        avail = fl;
        avail[0] = 1'b0; // preg 0 belongs to x0
        for (int k = 0; k < ren_width; k++) begin
            cand[k] = '0;
            cand_ok[k] = 1'b0;
            for (int p = phys_regs - 1; p >= 0; p--) begin
                if (avail[p]) begin
                    cand[k] = preg_bits'(p);
                    cand_ok[k] = 1'b1;
                end
            end
            if (cand_ok[k]) begin
                avail[cand[k]] = 1'b0;
            end
        end
    end

    // slots consume candidates in order, so step i+1 is the map after slot i
    always_comb begin
        int k;
        k = 0;
        step[0] = fl;
        for (int i = 0; i < ren_width; i++) begin
            step[i+1] = step[i];
            if (use_cand[i]) begin
                step[i+1][cand[k]] = 1'b0;
                k++;
            end
        end
    end

    always_comb begin
        com_mask = '0;
        for (int i = 0; i < ren_width; i++) begin
            if (com[i].valid) begin
                com_mask[com[i].old_preg] = 1'b1;
            end
        end
        com_mask[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < phys_regs; p++) begin
                fl[p] <= (p >= log_regs); // identity map owns 0..31
            end
        end else if (redir.valid) begin
            fl <= snaps[redir.br_tag] | com_mask;
        end else begin
            fl <= step[ren_width] | com_mask;
        end
    end

    // a commit free holds in every image, including one captured this cycle
    always_ff @(posedge clk) begin
        for (int s = 0; s < snap_count; s++) begin
            snaps[s] <= snaps[s] | com_mask;
        end
        for (int i = 0; i < ren_width; i++) begin
            if (snap_en[i]) begin
                snaps[snap_tag[i]] <= step[i+1] | com_mask;
            end
        end
    end

endmodule

// File: design/map_table.sv
/*
 * logical to physical register map
 * per-slot stepped reads give in-group bypass, branch slots save
 * the stepped map and a redirect loads it back
 */
`timescale 1ns/1ps

module map_table (
    input  logic clk,
    input  logic rst,
    // per slot {rs2, rs1, rd}
    input  logic [rename_cfg_pkg::ren_width-1:0][2:0][rename_cfg_pkg::lreg_bits-1:0] src,
    input  logic [rename_cfg_pkg::ren_width-1:0]                                     wr_en,
    input  logic [rename_cfg_pkg::ren_width-1:0][rename_cfg_pkg::preg_bits-1:0]      wr_preg,
    // per slot {prs2, prs1, old_prd}
    output logic [rename_cfg_pkg::ren_width-1:0][2:0][rename_cfg_pkg::preg_bits-1:0] prs,
    input  logic [rename_cfg_pkg::ren_width-1:0]                                     snap_en,
    input  logic [rename_cfg_pkg::ren_width-1:0][rename_cfg_pkg::tag_bits-1:0]       snap_tag,
    input  rename_types_pkg::redir_t                                                 redir
);
    import rename_cfg_pkg::*;

    logic [log_regs-1:0][preg_bits-1:0]                  mt;      // committed-to-rename map
    logic [snap_count-1:0][log_regs-1:0][preg_bits-1:0]  snaps;   // map per branch tag
    logic [ren_width:0][log_regs-1:0][preg_bits-1:0]     mt_step; // map seen by each slot

    // slot i reads mt_step[i], which already holds the writes of slots before it
    always_comb begin
        mt_step[0] = mt;
        mt_step[0][0] = '0;
        for (int i = 0; i < ren_width; i++) begin
            mt_step[i+1] = mt_step[i];
            if (wr_en[i]) begin
                mt_step[i+1][src[i][0]] = wr_preg[i];
            end
            mt_step[i+1][0] = '0; // x0 stays on preg 0
        end
    end

    always_comb begin
        for (int i = 0; i < ren_width; i++) begin
            for (int j = 0; j < 3; j++) begin
                prs[i][j] = mt_step[i][src[i][j]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < log_regs; l++) begin
                mt[l] <= preg_bits'(l); // identity
            end
        end else if (redir.valid) begin
            mt <= snaps[redir.br_tag];
        end else begin
            mt <= mt_step[ren_width];
        end
    end

    // a branch keeps the map as it stands after its own rename
    always_ff @(posedge clk) begin
        for (int i = 0; i < ren_width; i++) begin
            if (snap_en[i]) begin
                snaps[snap_tag[i]] <= mt_step[i+1];
            end
        end
    end

endmodule

// File: design/rename_queue.sv
/*
 * rename queue
 * in-order circular buffer, two writes and two head reads per cycle,
 * emptied by a flush
 */
`timescale 1ns/1ps

module rename_queue (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  logic [rename_cfg_pkg::ren_width-1:0]                        push,
    input  rename_types_pkg::ren_slot_t [rename_cfg_pkg::ren_width-1:0] wdata,
    output logic [$clog2(rename_cfg_pkg::rq_depth):0]                   space,
    input  logic [rename_cfg_pkg::ren_width-1:0]                        take,
    output rename_types_pkg::ren_slot_t [rename_cfg_pkg::ren_width-1:0] head,
    input  logic                                                        flush
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    ren_slot_t [rq_depth-1:0]                    mem;
    logic [$clog2(rq_depth)-1:0]                 front;  // oldest entry
    logic [$clog2(rq_depth):0]                   count;  // entries held
    logic [$clog2(rq_depth):0]                   n_in;
    logic [$clog2(rq_depth):0]                   n_out;
    logic [ren_width-1:0][$clog2(rq_depth)-1:0]  waddr;

    assign space = ($clog2(rq_depth) + 1)'(rq_depth) - count;

    // pushed slots land one after another behind the tail
    always_comb begin
        n_in = '0;
        for (int i = 0; i < ren_width; i++) begin
            waddr[i] = front + $clog2(rq_depth)'(count) + $clog2(rq_depth)'(n_in);
            if (push[i]) begin
                n_in = n_in + 1'b1;
            end
        end
    end

    always_comb begin
        n_out = '0;
        for (int i = 0; i < ren_width; i++) begin
            head[i] = mem[front + $clog2(rq_depth)'(i)];
            if (i >= count) begin
                head[i].valid = 1'b0; // past the tail
            end
            if (take[i] && head[i].valid) begin
                n_out = n_out + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ren_width; i++) begin
            if (push[i]) begin
                mem[waddr[i]] <= wdata[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            count <= '0;
        end else begin
            front <= front + $clog2(rq_depth)'(n_out);
            count <= count + n_in - n_out;
        end
    end

endmodule

// File: design/rename_top.sv
/*
 * rename stage top
 * picks the accepted prefix of decode slots, hands out free registers,
 * builds renamed entries and feeds the rename queue
 */
`timescale 1ns/1ps

module rename_top (
    input  logic                                                        clk,
    input  logic                                                        rst,
    input  rename_types_pkg::dec_slot_t [rename_cfg_pkg::ren_width-1:0] dec,
    output logic [rename_cfg_pkg::ren_width-1:0]                        ready,
    input  rename_types_pkg::com_slot_t [rename_cfg_pkg::ren_width-1:0] com,
    input  rename_types_pkg::redir_t                                    redir,
    output rename_types_pkg::ren_slot_t [rename_cfg_pkg::ren_width-1:0] ren,
    input  logic [rename_cfg_pkg::ren_width-1:0]                        take
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    logic [ren_width-1:0][preg_bits-1:0]       cand;
    logic [ren_width-1:0]                      cand_ok;
    logic [ren_width-1:0]                      use_cand; // slot takes a new preg
    logic [ren_width-1:0]                      snap_en;
    logic [ren_width-1:0][tag_bits-1:0]        snap_tag;
    logic [ren_width-1:0][2:0][lreg_bits-1:0]  src;
    logic [ren_width-1:0][preg_bits-1:0]       wr_preg;
    logic [ren_width-1:0][2:0][preg_bits-1:0]  prs;
    logic [$clog2(rq_depth):0]                 rq_space;
    ren_slot_t [ren_width-1:0]                 wdata;

    // accept in order until the first slot that cannot go
    always_comb begin
        int  n_acc;
        int  n_alloc;
        logic ok;
        n_acc = 0;
        n_alloc = 0;
        ok = !redir.valid;
        ready = '0;
        use_cand = '0;
        for (int i = 0; i < ren_width; i++) begin
            ok = ok && dec[i].valid && (n_acc < int'(rq_space)) &&
                 ((dec[i].rd == '0) || cand_ok[n_alloc]);
            ready[i] = ok;
            wr_preg[i] = cand[n_alloc]; // next unclaimed candidate
            if (ok) begin
                n_acc++;
                if (dec[i].rd != '0) begin
                    use_cand[i] = 1'b1;
                    n_alloc++;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ren_width; i++) begin
            src[i][0] = dec[i].rd;
            src[i][1] = dec[i].rs1;
            src[i][2] = dec[i].rs2;
            snap_en[i] = ready[i] && dec[i].is_branch;
            snap_tag[i] = dec[i].br_tag;
            wdata[i].valid = ready[i];
            wdata[i].pc = dec[i].pc;
            wdata[i].rd = dec[i].rd;
            wdata[i].prd = use_cand[i] ? wr_preg[i] : '0;
            wdata[i].prs1 = prs[i][1];
            wdata[i].prs2 = prs[i][2];
            wdata[i].old_prd = prs[i][0];
        end
    end

    free_list u_free_list (
        .clk      (clk),
        .rst      (rst),
        .cand     (cand),
        .cand_ok  (cand_ok),
        .use_cand (use_cand),
        .snap_en  (snap_en),
        .snap_tag (snap_tag),
        .com      (com),
        .redir    (redir)
    );

    map_table u_map_table (
        .clk      (clk),
        .rst      (rst),
        .src      (src),
        .wr_en    (use_cand),
        .wr_preg  (wr_preg),
        .prs      (prs),
        .snap_en  (snap_en),
        .snap_tag (snap_tag),
        .redir    (redir)
    );

    rename_queue u_rename_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (ready),
        .wdata (wdata),
        .space (rq_space),
        .take  (take),
        .head  (ren),
        .flush (redir.valid)
    );

endmodule

// File: verification/rename_assertions.sv
/*
 * concurrent checks on the rename top
 * ready prefix, empty output after redirect or reset, no prd 0 for a real rd
 */
`timescale 1ns/1ps

module rename_assertions (
    input logic                                                        clk,
    input logic                                                        rst,
    input logic [rename_cfg_pkg::ren_width-1:0]                        ready,
    input rename_types_pkg::redir_t                                    redir,
    input rename_types_pkg::ren_slot_t [rename_cfg_pkg::ren_width-1:0] ren
);
    import rename_cfg_pkg::*;

    int   fails = 0; // failed assertion count
    logic any_valid;

    always_comb begin
        any_valid = 1'b0;
        for (int i = 0; i < ren_width; i++) begin
            any_valid = any_valid | ren[i].valid;
        end
    end

    a_ready_prefix: assert property (@(posedge clk) disable iff (rst) ready[1] |-> ready[0])
        else begin
            fails++;
            $error("ready accepts slot 1 while refusing slot 0");
        end

    a_flush_empty: assert property (@(posedge clk) (rst || redir.valid) |=> !any_valid)
        else begin
            fails++;
            $error("ren shows a valid entry right after a redirect or reset");
        end

    for (genvar i = 0; i < ren_width; i++) begin : g_prd
        a_prd_nonzero: assert property (@(posedge clk) disable iff (rst)
            (ren[i].valid && ren[i].rd != '0) |-> ren[i].prd != '0)
            else begin
                fails++;
                $error("ren slot %0d carries prd 0 for a nonzero rd", i);
            end
    end

endmodule

bind rename_top rename_assertions u_rename_assertions (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .redir (redir),
    .ren   (ren)
);

// File: verification/tb_rename_top.sv
/*
 * testbench for the rename stage
 * random decode, take, commit and redirect traffic, checked every cycle
 * against a model of the map, free list, snapshots and queue
 */
`timescale 1ns/1ps

module tb_rename_top;
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    localparam int period     = 8;
    localparam int num_cycles = 800;

    logic                      clk;
    logic                      rst;
    dec_slot_t [ren_width-1:0] dec;
    logic [ren_width-1:0]      ready;
    com_slot_t [ren_width-1:0] com;
    redir_t                    redir;
    ren_slot_t [ren_width-1:0] ren;
    logic [ren_width-1:0]      take;
    logic [15:0]               lfsr;
    int                        errors;

    logic [log_regs-1:0][preg_bits-1:0]                 m_map;
    logic [phys_regs-1:0]                               m_free;      // 1 = free
    logic [snap_count-1:0][log_regs-1:0][preg_bits-1:0] m_snap_map;
    logic [snap_count-1:0][phys_regs-1:0]               m_snap_free;
    logic [snap_count-1:0]                              m_snap_rec;  // tag holds an image
    ren_slot_t                                          m_q[$];      // expected queue
    logic [preg_bits-1:0]                               pool[$];     // drained old_prd values

    rename_top dut (
        .clk   (clk),
        .rst   (rst),
        .dec   (dec),
        .ready (ready),
        .com   (com),
        .redir (redir),
        .ren   (ren),
        .take  (take)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #((num_cycles + 3 + 50) * period);
        $display("watchdog expired before the random test finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned draw(input int n);
        int unsigned v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic make_stimulus(input int c);
        int          n_take;
        int unsigned tag;
        for (int i = 0; i < ren_width; i++) begin
            dec[i].valid = (draw(2) != 0);
            dec[i].pc = 16'(draw(16));
            dec[i].rd = (draw(3) == 0) ? '0 : lreg_bits'(draw(5)); // x0 often
            dec[i].rs1 = lreg_bits'(draw(5));
            dec[i].rs2 = lreg_bits'(draw(5));
            dec[i].is_branch = (draw(2) == 0);
            dec[i].br_tag = tag_bits'(draw(2));
        end
        if (draw(1) != 0) begin
            dec[1].rs1 = dec[0].rd; // in-group dependency
        end
        n_take = (c >= 60 && c < 90) ? 0 : int'(draw(2) % 3); // hold take low for a while
        take = '0;
        for (int i = 0; i < ren_width; i++) begin
            take[i] = (i < n_take) && (i < m_q.size());
        end
        com = '0;
        for (int i = 0; i < ren_width; i++) begin
            if (c >= 60 && pool.size() > 0 && draw(1) != 0) begin
                com[i].valid = 1'b1;
                com[i].old_preg = pool.pop_front();
            end
        end
        redir = '0;
        if (c >= 90 && draw(4) == 0) begin
            tag = draw(2);
            if (m_snap_rec[tag]) begin // only tags with a recorded image
                redir.valid = 1'b1;
                redir.br_tag = tag_bits'(tag);
            end
        end
    endtask

    task automatic check_and_step();
        logic [log_regs-1:0][preg_bits-1:0] map_s;
        logic [phys_regs-1:0]               free_s;
        logic [phys_regs-1:0]               com_mask;
        logic [ren_width-1:0]               exp_ready;
        ren_slot_t [ren_width-1:0]          ent;
        ren_slot_t                          gone;
        logic                               ok;
        int                                 n_acc;
        int                                 p;
        map_s = m_map;
        free_s = m_free;
        com_mask = '0;
        for (int i = 0; i < ren_width; i++) begin
            if (com[i].valid) begin
                com_mask[com[i].old_preg] = 1'b1;
            end
        end
        com_mask[0] = 1'b0;
        ok = !redir.valid;
        n_acc = 0;
        for (int i = 0; i < ren_width; i++) begin
            p = 0;
            for (int r = phys_regs - 1; r > 0; r--) begin
                if (free_s[r]) begin
                    p = r; // lowest free, never 0
                end
            end
            ok = ok && dec[i].valid && (n_acc < rq_depth - m_q.size()) &&
                 (dec[i].rd == '0 || p != 0);
            exp_ready[i] = ok;
            ent[i] = '0;
            if (ok) begin
                n_acc++;
                ent[i].valid = 1'b1;
                ent[i].pc = dec[i].pc;
                ent[i].rd = dec[i].rd;
                ent[i].prs1 = map_s[dec[i].rs1];
                ent[i].prs2 = map_s[dec[i].rs2];
                ent[i].old_prd = map_s[dec[i].rd];
                if (dec[i].rd != '0) begin
                    ent[i].prd = preg_bits'(p);
                    map_s[dec[i].rd] = preg_bits'(p);
                    free_s[p] = 1'b0;
                end
                if (dec[i].is_branch) begin
                    m_snap_map[dec[i].br_tag] = map_s;
                    m_snap_free[dec[i].br_tag] = free_s;
                    m_snap_rec[dec[i].br_tag] = 1'b1;
                end
            end
        end
        assert (ready === exp_ready) else begin
            $display("mismatch at %0t: ready expected %b, got %b", $time, exp_ready, ready);
            errors++;
        end
        for (int i = 0; i < ren_width; i++) begin
            if (i < m_q.size()) begin
                assert (ren[i] === m_q[i]) else begin
                    $display("mismatch at %0t: ren[%0d] expected %h, got %h",
                             $time, i, m_q[i], ren[i]);
                    errors++;
                end
            end else begin
                assert (ren[i].valid === 1'b0) else begin
                    $display("mismatch at %0t: ren[%0d] valid past the queue tail", $time, i);
                    errors++;
                end
            end
        end
        if (redir.valid) begin
            m_map = m_snap_map[redir.br_tag];
            m_free = m_snap_free[redir.br_tag] | com_mask;
            m_q.delete();
        end else begin
            for (int i = 0; i < ren_width; i++) begin
                if (take[i]) begin
                    gone = m_q.pop_front();
                    pool.push_back(gone.old_prd);
                end
            end
            for (int i = 0; i < ren_width; i++) begin
                if (exp_ready[i]) begin
                    m_q.push_back(ent[i]);
                end
            end
            m_map = map_s;
            m_free = free_s | com_mask;
        end
        for (int s = 0; s < snap_count; s++) begin
            m_snap_free[s] = m_snap_free[s] | com_mask; // frees repair every image
        end
    endtask

    initial begin
        errors = 0;
        lfsr = 16'd40;
        rst = 1'b1;
        dec = '0;
        com = '0;
        redir = '0;
        take = '0;
        for (int l = 0; l < log_regs; l++) begin
            m_map[l] = preg_bits'(l);
        end
        for (int r = 0; r < phys_regs; r++) begin
            m_free[r] = (r >= log_regs);
        end
        m_snap_map = '0;
        m_snap_free = '0;
        m_snap_rec = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int c = 0; c < num_cycles; c++) begin
            make_stimulus(c);
            #1;
            check_and_step();
            @(negedge clk);
        end
        $display("closing: %0d model mismatches, %0d assertion failures",
                 errors, dut.u_rename_assertions.fails);
        if (errors == 0 && dut.u_rename_assertions.fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
design/rename_cfg_pkg.sv
design/rename_types_pkg.sv
design/free_list.sv
design/map_table.sv
design/rename_queue.sv
design/rename_top.sv
verification/rename_assertions.sv
verification/tb_rename_top.sv

// File: Bender.yml
package:
  name: rename_stage

sources:
  - design/rename_cfg_pkg.sv
  - design/rename_types_pkg.sv
  - design/free_list.sv
  - design/map_table.sv
  - design/rename_queue.sv
  - design/rename_top.sv
  - target: simulation
    files:
      - verification/rename_assertions.sv
      - verification/tb_rename_top.sv
